// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = csr_unit_tb
FILELIST = sim.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== csr_file.sv ====
`default_nettype none

module csr_file #(
    parameter logic [csr_pkg::XLEN-1:0] RESET_MTVEC = '0
) (
    input  logic  clk,
    input  logic  rst,
    sys_op_if.dst in,
    sys_op_if.src out
);
    import csr_pkg::*;

    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;

    logic            csr_op;
    logic            hit;
    logic            wr_en;
    logic [XLEN-1:0] old_val;
    logic [XLEN-1:0] new_val;
    logic [XLEN-1:0] result_d;
    sys_op_e         op_d;

    assign csr_op = is_csr_op(in.op);
    assign hit    = csr_known(in.csr_addr);

    // CSRRS and CSRRC with rs1 = x0 are pure reads
    assign wr_en = in.valid && csr_op && hit && ((in.op == op_csrrw) || !in.rs1_zero);

    always_comb begin
        case (in.csr_addr)
            CSR_MSTATUS: old_val = mstatus;
            CSR_MTVEC:   old_val = mtvec;
            CSR_MEPC:    old_val = mepc;
            CSR_MCAUSE:  old_val = mcause;
            default:     old_val = '0;
        endcase
    end

    always_comb begin
        case (in.op)
            op_csrrs: new_val = old_val | in.operand;
            op_csrrc: new_val = old_val & ~in.operand;
            default:  new_val = in.operand;
        endcase
    end

    always_comb begin
        result_d = '0;
        op_d     = in.op;
        if (csr_op) begin
            if (hit) begin
                result_d = old_val;
            end else begin
                op_d = op_illegal;
            end
        end else if (in.op == op_ecall) begin
            result_d = mtvec; // Trap target
        end else if (in.op == op_mret) begin
            result_d = mepc;  // Return target
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus <= MSTATUS_MPP_FIXED;
            mtvec   <= RESET_MTVEC;
            mepc    <= '0;
            mcause  <= '0;
        end else if (wr_en) begin
            case (in.csr_addr)
                CSR_MSTATUS: mstatus <= (new_val & MSTATUS_WMASK) | MSTATUS_MPP_FIXED;
                CSR_MTVEC:   mtvec   <= {new_val[XLEN-1:2], 2'b00};
                CSR_MEPC:    mepc    <= {new_val[XLEN-1:2], 2'b00};
                default:     mcause  <= new_val;
            endcase
        end else if (in.valid && (in.op == op_ecall)) begin
            mepc                  <= in.pc;
            mcause                <= CAUSE_ECALL_M;
            mstatus[MSTATUS_MPIE] <= mstatus[MSTATUS_MIE];
            mstatus[MSTATUS_MIE]  <= 1'b0; // Interrupts off inside the handler
        end else if (in.valid && (in.op == op_mret)) begin
            mstatus[MSTATUS_MIE]  <= mstatus[MSTATUS_MPIE];
            mstatus[MSTATUS_MPIE] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out.valid <= 1'b0;
            out.op    <= op_none;
        end else begin
            out.valid <= in.valid;
            out.op    <= op_d;
        end
    end

    always_ff @(posedge clk) begin
        out.pc       <= in.pc;
        out.csr_addr <= in.csr_addr;
        out.operand  <= in.operand;
        out.rs1_zero <= in.rs1_zero;
        out.rd       <= in.rd;
        out.result   <= result_d;
    end

    // Any mstatus read handed to write-back shows MPP as machine mode
    a_mpp_fixed: assert property (
        @(posedge clk) disable iff (rst)
        (out.valid && is_csr_op(out.op) && (out.csr_addr == CSR_MSTATUS))
            |-> ((out.result & MSTATUS_MPP_FIXED) == MSTATUS_MPP_FIXED)
    );

endmodule

`default_nettype wire

// ==== csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    localparam int XLEN = 32;

    // Operation kinds carried down the pipeline
    typedef enum logic [2:0] {
        op_none    = 3'd0,
        op_csrrw   = 3'd1,
        op_csrrs   = 3'd2,
        op_csrrc   = 3'd3,
        op_ecall   = 3'd4,
        op_mret    = 3'd5,
        op_illegal = 3'd6
    } sys_op_e;

    // Machine-mode CSR addresses implemented here
    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;

    // mstatus field positions
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;

    localparam logic [XLEN-1:0] MSTATUS_MPP_FIXED = 32'h0000_1800; // MPP stuck at machine mode
    localparam logic [XLEN-1:0] MSTATUS_WMASK =
        (32'h1 << MSTATUS_MIE) | (32'h1 << MSTATUS_MPIE);

    localparam logic [XLEN-1:0] CAUSE_ECALL_M = 32'd11;

    // SYSTEM opcode and its funct3 and funct12 encodings
    localparam logic [6:0]  OPC_SYSTEM = 7'b111_0011;
    localparam logic [2:0]  F3_PRIV    = 3'b000;
    localparam logic [2:0]  F3_CSRRW   = 3'b001;
    localparam logic [2:0]  F3_CSRRS   = 3'b010;
    localparam logic [2:0]  F3_CSRRC   = 3'b011;
    localparam logic [11:0] F12_ECALL  = 12'h000;
    localparam logic [11:0] F12_MRET   = 12'h302;

    // True for the three register-form CSR operations
    function automatic logic is_csr_op(input sys_op_e op);
        return (op == op_csrrw) || (op == op_csrrs) || (op == op_csrrc);
    endfunction

    // True when the address names one of the four implemented CSRs
    function automatic logic csr_known(input logic [11:0] addr);
        return (addr == CSR_MSTATUS) || (addr == CSR_MTVEC) ||
               (addr == CSR_MEPC) || (addr == CSR_MCAUSE);
    endfunction

    // True for the trap entry and return operations that change the pc
    function automatic logic is_redirect_op(input sys_op_e op);
        return (op == op_ecall) || (op == op_mret);
    endfunction

endpackage

`default_nettype wire

// ==== csr_unit_tb.sv ====
`default_nettype none

module csr_unit_tb;
    import csr_pkg::*;

    localparam logic [31:0] MTVEC_AT_RESET = 32'h0000_0200;
    localparam int N_DIRECTED = 24;
    localparam int N_RANDOM   = 300;
    localparam int DRAIN      = 6;
    // Each random item takes one cycle plus at most four idle cycles
    localparam int MAX_CYCLES = 3 + N_DIRECTED + N_RANDOM * 5 + DRAIN + 20;

    typedef struct packed {
        logic        rd_we;
        logic [4:0]  rd_addr;
        logic [31:0] rd_data;
        logic        redirect;
        logic [31:0] redirect_pc;
        logic        illegal;
        logic [31:0] cycle;     // Cycle in which the output must show up
    } exp_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        in_valid;
    logic [31:0] in_instr;
    logic [31:0] in_pc;
    logic [31:0] in_rs1_data;
    logic        out_valid;
    logic        out_rd_we;
    logic [4:0]  out_rd_addr;
    logic [31:0] out_rd_data;
    logic        out_redirect;
    logic [31:0] out_redirect_pc;
    logic        out_illegal;

    logic [31:0] cycle = '0;
    logic [15:0] lfsr = 16'd43563;
    exp_t        exp_q[$];

    // Reference copy of the CSRs
    logic [31:0] m_mstatus;
    logic [31:0] m_mtvec;
    logic [31:0] m_mepc;
    logic [31:0] m_mcause;

    csr_unit_top #(
        .RESET_MTVEC (MTVEC_AT_RESET)
    ) DUT (
        .clk             (clk),
        .rst             (rst),
        .in_valid        (in_valid),
        .in_instr        (in_instr),
        .in_pc           (in_pc),
        .in_rs1_data     (in_rs1_data),
        .out_valid       (out_valid),
        .out_rd_we       (out_rd_we),
        .out_rd_addr     (out_rd_addr),
        .out_rd_data     (out_rd_data),
        .out_redirect    (out_redirect),
        .out_redirect_pc (out_redirect_pc),
        .out_illegal     (out_illegal)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 32'd1;
        if (cycle >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not finish", cycle);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    // Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic logic [31:0] csr_instr(input logic [2:0] f3, input logic [11:0] addr,
                                              input logic [4:0] rs1f, input logic [4:0] rd);
        return {addr, rs1f, f3, rd, 7'h73};
    endfunction

    // Applies one instruction to the reference CSRs and returns what the outputs must show
    function automatic exp_t model_step(input logic [31:0] instr, input logic [31:0] pc,
                                        input logic [31:0] rs1_data);
        exp_t        e;
        logic [2:0]  f3;
        logic [11:0] addr;
        logic [31:0] old_v;
        logic [31:0] new_v;
        logic        known;
        e = '0;
        f3 = instr[14:12];
        addr = instr[31:20];
        e.rd_addr = instr[11:7];
        known = 1'b1;
        case (addr)
            CSR_MSTATUS: old_v = m_mstatus;
            CSR_MTVEC:   old_v = m_mtvec;
            CSR_MEPC:    old_v = m_mepc;
            CSR_MCAUSE:  old_v = m_mcause;
            default: begin
                old_v = '0;
                known = 1'b0;
            end
        endcase
        if (instr[6:0] != 7'h73) begin
            e.illegal = 1'b0; // Plain no-op on this path
        end else if (f3 == 3'd0 && addr == 12'h000) begin
            e.redirect = 1'b1;
            e.redirect_pc = m_mtvec;
            m_mepc = pc;
            m_mcause = 32'd11;
            m_mstatus[MSTATUS_MPIE] = m_mstatus[MSTATUS_MIE];
            m_mstatus[MSTATUS_MIE] = 1'b0;
        end else if (f3 == 3'd0 && addr == 12'h302) begin
            e.redirect = 1'b1;
            e.redirect_pc = m_mepc;
            m_mstatus[MSTATUS_MIE] = m_mstatus[MSTATUS_MPIE];
            m_mstatus[MSTATUS_MPIE] = 1'b1;
        end else if (f3 == 3'd0 || f3 >= 3'd4 || !known) begin
            e.illegal = 1'b1;
        end else begin
            e.rd_we = (instr[11:7] != 5'd0);
            e.rd_data = old_v;
            if (f3 == 3'd1) new_v = rs1_data;
            else if (f3 == 3'd2) new_v = old_v | rs1_data;
            else new_v = old_v & ~rs1_data;
            if (f3 == 3'd1 || instr[19:15] != 5'd0) begin
                case (addr)
                    CSR_MSTATUS: m_mstatus = (new_v & 32'h0000_0088) | 32'h0000_1800;
                    CSR_MTVEC:   m_mtvec = new_v & ~32'h3;
                    CSR_MEPC:    m_mepc = new_v & ~32'h3;
                    default:     m_mcause = new_v;
                endcase
            end
        end
        return e;
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("FAILED at time %0t: %s is %h, expected %h", $time, what, got, want);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic send(input logic [31:0] instr, input logic [31:0] pc,
                        input logic [31:0] rs1);
        exp_t e;
        in_valid = 1'b1;
        in_instr = instr;
        in_pc = pc;
        in_rs1_data = rs1;
        e = model_step(instr, pc, rs1);
        e.cycle = cycle + 32'd3;
        exp_q.push_back(e);
        @(posedge clk);
        #10;
        in_valid = 1'b0;
    endtask

    task automatic idle();
        in_valid = 1'b0;
        @(posedge clk);
        #10;
    endtask

    always @(negedge clk) begin
        exp_t e;
        if (!rst && out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("An output appeared at time %0t with no item outstanding", $time);
                $display("TEST RESULT: FAIL");
                $fatal(1, "unexpected output");
            end else begin
                e = exp_q.pop_front();
                check("output cycle", cycle, e.cycle);
                check("out_rd_we", 32'(out_rd_we), 32'(e.rd_we));
                check("out_redirect", 32'(out_redirect), 32'(e.redirect));
                check("out_illegal", 32'(out_illegal), 32'(e.illegal));
                if (e.rd_we) check("out_rd_addr", 32'(out_rd_addr), 32'(e.rd_addr));
                if (e.rd_we) check("out_rd_data", out_rd_data, e.rd_data);
                if (e.redirect) check("out_redirect_pc", out_redirect_pc, e.redirect_pc);
            end
        end
    end

    initial begin
        logic [31:0] kind;
        logic [31:0] f3;
        logic [31:0] sel;
        logic [31:0] rs1f;
        logic [31:0] rd;
        logic [31:0] operand;
        logic [31:0] pc;
        logic [31:0] instr;
        logic [11:0] addr;
        rst = 1'b1;
        in_valid = 1'b0;
        in_instr = '0;
        in_pc = '0;
        in_rs1_data = '0;
        m_mstatus = 32'h0000_1800;
        m_mtvec = MTVEC_AT_RESET;
        m_mepc = '0;
        m_mcause = '0;
        repeat (3) @(posedge clk);
        #10;
        rst = 1'b0;

        // Reset values, read back with rs1 = x0 so the operand must be ignored
        send(csr_instr(F3_CSRRS, CSR_MSTATUS, 5'd0, 5'd1), 32'h0000_0100, 32'hFFFF_FFFF);
        send(csr_instr(F3_CSRRS, CSR_MTVEC, 5'd0, 5'd2), 32'h0000_0104, 32'hFFFF_FFFF);
        send(csr_instr(F3_CSRRS, CSR_MEPC, 5'd0, 5'd3), 32'h0000_0108, 32'hFFFF_FFFF);
        send(csr_instr(F3_CSRRS, CSR_MCAUSE, 5'd0, 5'd4), 32'h0000_010c, 32'hFFFF_FFFF);
        send(csr_instr(F3_CSRRW, CSR_MSTATUS, 5'd5, 5'd6), 32'h0000_0110, 32'hFFFF_FFFF);
        send(csr_instr(F3_CSRRS, CSR_MSTATUS, 5'd0, 5'd7), 32'h0000_0114, 32'h0);
        send(csr_instr(F3_CSRRW, CSR_MTVEC, 5'd5, 5'd8), 32'h0000_0118, 32'h0000_2007);
        send(csr_instr(F3_CSRRW, CSR_MEPC, 5'd5, 5'd0), 32'h0000_011c, 32'h0000_3003);
        send(csr_instr(F3_CSRRC, CSR_MSTATUS, 5'd5, 5'd9), 32'h0000_0120, 32'h0000_0080);
        idle();
        send(csr_instr(F3_CSRRC, CSR_MSTATUS, 5'd0, 5'd9), 32'h0000_0124, 32'hFFFF_FFFF);
        send(32'h0000_0073, 32'h0000_4560, 32'h0);    // ECALL with MIE set
        send(csr_instr(F3_CSRRS, CSR_MEPC, 5'd0, 5'd10), 32'h0000_2000, 32'h0);
        send(csr_instr(F3_CSRRS, CSR_MCAUSE, 5'd0, 5'd11), 32'h0000_2004, 32'h0);
        send(csr_instr(F3_CSRRS, CSR_MSTATUS, 5'd0, 5'd12), 32'h0000_2008, 32'h0);
        send(32'h3020_0073, 32'h0000_200c, 32'h0);    // MRET
        send(csr_instr(F3_CSRRS, CSR_MSTATUS, 5'd0, 5'd13), 32'h0000_4560, 32'h0);
        send(csr_instr(F3_CSRRW, 12'h340, 5'd5, 5'd14), 32'h0000_4564, 32'hFFFF_FFFF);
        send(csr_instr(3'b101, CSR_MSTATUS, 5'd5, 5'd15), 32'h0000_4568, 32'hFFFF_FFFF);
        send(32'h0020_8033, 32'h0000_456c, 32'h0000_0001);
        send(csr_instr(F3_CSRRS, CSR_MSTATUS, 5'd0, 5'd16), 32'h0000_4570, 32'h0);

        for (int n = 0; n < N_RANDOM; n++) begin
            kind = take_bits(3);
            f3 = 32'd1 + (take_bits(2) % 3);
            sel = take_bits(3);
            rs1f = (take_bits(2) == 0) ? 32'd0 : take_bits(5);
            rd = take_bits(5);
            operand = take_bits(32);
            pc = take_bits(30) << 2;
            case (sel[2:0])
                3'd0, 3'd4: addr = CSR_MSTATUS;
                3'd1, 3'd5: addr = CSR_MTVEC;
                3'd2:       addr = CSR_MEPC;
                3'd3:       addr = CSR_MCAUSE;
                default:    addr = 12'hB00 | {11'd0, sel[0]}; // Counters are not implemented
            endcase
            case (kind[2:0])
                3'd4:    instr = 32'h0000_0073;
                3'd5:    instr = 32'h3020_0073;
                3'd6:    instr = csr_instr(3'd4 + f3[2:0], addr, rs1f[4:0], rd[4:0]);
                3'd7:    instr = {operand[31:7], 7'h33};
                default: instr = csr_instr(f3[2:0], addr, rs1f[4:0], rd[4:0]);
            endcase
            send(instr, pc, operand);
            if (take_bits(2) == 0) repeat (take_bits(2) + 1) idle();
        end

        repeat (DRAIN) idle();
        if (exp_q.size() != 0) begin
            $display("%0d expected outputs never appeared", exp_q.size());
            $display("TEST RESULT: FAIL");
            $fatal(1, "missing outputs");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== csr_unit_top.sv ====
`default_nettype none

module csr_unit_top #(
    parameter logic [csr_pkg::XLEN-1:0] RESET_MTVEC = '0
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  logic [31:0] in_instr,
    input  logic [31:0] in_pc,
    input  logic [31:0] in_rs1_data,
    output logic        out_valid,
    output logic        out_rd_we,
    output logic [4:0]  out_rd_addr,
    output logic [31:0] out_rd_data,
    output logic        out_redirect,
    output logic [31:0] out_redirect_pc,
    output logic        out_illegal
);

    sys_op_if dec_to_csr ();
    sys_op_if csr_to_wb ();

    sys_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_instr    (in_instr),
        .in_pc       (in_pc),
        .in_rs1_data (in_rs1_data),
        .out         (dec_to_csr.src)
    );

    // All CSR state changes happen here, in program order
    csr_file #(
        .RESET_MTVEC (RESET_MTVEC)
    ) u_csr_file (
        .clk (clk),
        .rst (rst),
        .in  (dec_to_csr.dst),
        .out (csr_to_wb.src)
    );

    sys_writeback u_writeback (
        .clk             (clk),
        .rst             (rst),
        .in              (csr_to_wb.dst),
        .out_valid       (out_valid),
        .out_rd_we       (out_rd_we),
        .out_redirect    (out_redirect),
        .out_illegal     (out_illegal),
        .out_rd_addr     (out_rd_addr),
        .out_rd_data     (out_rd_data),
        .out_redirect_pc (out_redirect_pc)
    );

endmodule

`default_nettype wire

// ==== sim.f ====
csr_pkg.sv
sys_op_if.sv
sys_decode.sv
csr_file.sv
sys_writeback.sv
csr_unit_top.sv
csr_unit_tb.sv

// ==== sys_decode.sv ====
`default_nettype none

module sys_decode (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  logic [31:0] in_instr,
    input  logic [31:0] in_pc,
    input  logic [31:0] in_rs1_data,
    sys_op_if.src       out
);
    import csr_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [11:0] funct12;
    logic [4:0]  rs1_field;
    logic [4:0]  rd_field;
    sys_op_e     op_d;

    assign opcode    = in_instr[6:0];
    assign rd_field  = in_instr[11:7];
    assign funct3    = in_instr[14:12];
    assign rs1_field = in_instr[19:15];
    assign funct12   = in_instr[31:20]; // Also the CSR address for CSR forms

    always_comb begin
        op_d = op_none; // Anything outside SYSTEM is a no-op on this path
        if (opcode == OPC_SYSTEM) begin
            case (funct3)
                F3_PRIV: begin
                    if (funct12 == F12_ECALL) begin
                        op_d = op_ecall;
                    end else if (funct12 == F12_MRET) begin
                        op_d = op_mret;
                    end else begin
                        op_d = op_illegal;
                    end
                end
                F3_CSRRW: op_d = op_csrrw;
                F3_CSRRS: op_d = op_csrrs;
                F3_CSRRC: op_d = op_csrrc;
                default:  op_d = op_illegal; // Immediate forms and reserved funct3
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out.valid <= 1'b0;
            out.op    <= op_none;
        end else begin
            out.valid <= in_valid;
            out.op    <= op_d;
        end
    end

    always_ff @(posedge clk) begin
        out.pc       <= in_pc;
        out.csr_addr <= funct12;
        out.operand  <= in_rs1_data;
        out.rs1_zero <= (rs1_field == 5'd0);
        out.rd       <= rd_field;
    end

    // The CSR stage fills this in
    assign out.result = '0;

    // A valid item must carry a resolved operation into the CSR stage
    a_op_known: assert property (
        @(posedge clk) disable iff (rst)
        out.valid |-> !$isunknown(out.op)
    );

endmodule

`default_nettype wire

// ==== sys_op_if.sv ====
`default_nettype none

// One decoded system operation travelling from one stage to the next
interface sys_op_if;
    import csr_pkg::*;

    logic            valid;     // One cycle per item, no handshake
    sys_op_e         op;
    logic [XLEN-1:0] pc;
    logic [11:0]     csr_addr;
    logic [XLEN-1:0] operand;   // rs1 data
    logic            rs1_zero;  // rs1 field was x0
    logic [4:0]      rd;
    logic [XLEN-1:0] result;    // Only meaningful after the CSR stage

    modport src (
        output valid, op, pc, csr_addr, operand, rs1_zero, rd, result
    );

    modport dst (
        input valid, op, pc, csr_addr, operand, rs1_zero, rd, result
    );

endinterface

`default_nettype wire

// ==== sys_writeback.sv ====
`default_nettype none

module sys_writeback (
    input  logic        clk,
    input  logic        rst,
    sys_op_if.dst       in,
    output logic        out_valid,
    output logic        out_rd_we,
    output logic        out_redirect,
    output logic        out_illegal,
    output logic [4:0]  out_rd_addr,
    output logic [31:0] out_rd_data,
    output logic [31:0] out_redirect_pc
);
    import csr_pkg::*;

    logic rd_we_d;
    logic redirect_d;
    logic illegal_d;

    // Writes to x0 are dropped here rather than in the register file
    assign rd_we_d    = in.valid && is_csr_op(in.op) && (in.rd != 5'd0);
    assign redirect_d = in.valid && is_redirect_op(in.op);
    assign illegal_d  = in.valid && (in.op == op_illegal);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid    <= 1'b0;
            out_rd_we    <= 1'b0;
            out_redirect <= 1'b0;
            out_illegal  <= 1'b0;
        end else begin
            out_valid    <= in.valid;
            out_rd_we    <= rd_we_d;
            out_redirect <= redirect_d;
            out_illegal  <= illegal_d;
        end
    end

    always_ff @(posedge clk) begin
        out_rd_addr     <= in.rd;
        out_rd_data     <= in.result;
        out_redirect_pc <= in.result; // mtvec for ECALL, mepc for MRET
    end

    // A CSR write-back and a pc redirect never come from the same item
    a_we_xor_redirect: assert property (
        @(posedge clk) disable iff (rst)
        !(out_rd_we && out_redirect)
    );

endmodule

`default_nettype wire
